// File: all.f
hdl/xc_pkg.sv
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/xc_correlator.sv
hdl/xc_control.sv
hdl/xc_top.sv
testbench/tb_clock.sv
testbench/xc_assert.sv
testbench/xc_checker.sv
testbench/xc_tb.sv

// File: hdl/uart_pkg.sv
// serial link types and host command codes.
// used by the receiver, the control FSM and the top level.
`default_nettype none

package uart_pkg;

    // one byte on the wire.
    typedef logic [7:0] uart_byte_t;

    // host commands.
    localparam uart_byte_t CMD_START = 8'h01;
    localparam uart_byte_t CMD_STOP  = 8'h02;

    // received byte with its one cycle strobe.
    typedef struct packed {
        uart_byte_t data;
        logic       valid;
    } uart_rx_t;

endpackage

`default_nettype wire

// File: hdl/uart_rx.sv
// 8N1 serial receiver, one valid strobe per good byte.
`timescale 1ns/10ps
`default_nettype none

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               rx,
    output uart_pkg::uart_rx_t rx_out
);
    import uart_pkg::*;

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);
    localparam logic [CW-1:0] HALF_BIT = CW'(CLKS_PER_BIT / 2 - 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_e;

    rx_state_e  state;
    logic       rx_meta;
    logic       rx_sync;
    logic [CW-1:0] tick_cnt;
    logic [2:0] bit_idx;
    logic       valid;
    uart_byte_t shift;

    // two flop synchronizer, line idles high.
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // ========================================
    // frame FSM, samples at mid bit.
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= rx_idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            valid    <= 1'b0;
        end else begin
            valid <= 1'b0;
            case (state)
                rx_idle: begin
                    // falling edge, aim at middle of start bit.
                    if (!rx_sync) begin
                        tick_cnt <= HALF_BIT;
                        state    <= rx_start;
                    end
                end
                rx_start: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else if (!rx_sync) begin
                        tick_cnt <= FULL_BIT;
                        bit_idx  <= '0;
                        state    <= rx_data;
                    end else begin
                        // glitch, not a start bit.
                        state <= rx_idle;
                    end
                end
                rx_data: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else begin
                        tick_cnt <= FULL_BIT;
                        bit_idx  <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end
                    end
                end
                rx_stop: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else begin
                        // framing error drops the byte.
                        valid <= rx_sync;
                        state <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // data shift, lsb arrives first.
    always_ff @(posedge clk) begin
        if (state == rx_data && tick_cnt == '0) begin
            shift <= {rx_sync, shift[7:1]};
        end
    end

    assign rx_out.data  = shift;
    assign rx_out.valid = valid;

endmodule

`default_nettype wire

// File: hdl/uart_tx.sv
// 8N1 serial transmitter, one cycle load pulse, busy until the stop bit ends.
`timescale 1ns/10ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 load,
    input  uart_pkg::uart_byte_t data,
    output logic                 tx,
    output logic                 busy
);
    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] FULL_BIT = CW'(CLKS_PER_BIT - 1);

    logic [CW-1:0] tick_cnt;
    logic [3:0]    bits_left;
    logic [8:0]    shifter;
    logic          bit_end;

    // end of the current bit period.
    assign bit_end = busy && (tick_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            tx        <= 1'b1;
            busy      <= 1'b0;
            tick_cnt  <= '0;
            bits_left <= '0;
        end else if (!busy) begin
            tx <= 1'b1;
            if (load) begin
                // start bit goes out right away.
                tx        <= 1'b0;
                busy      <= 1'b1;
                tick_cnt  <= FULL_BIT;
                bits_left <= 4'd9;
            end
        end else if (bit_end) begin
            if (bits_left == '0) begin
                // stop bit done.
                busy <= 1'b0;
                tx   <= 1'b1;
            end else begin
                tx        <= shifter[0];
                tick_cnt  <= FULL_BIT;
                bits_left <= bits_left - 1'b1;
            end
        end else begin
            tick_cnt <= tick_cnt - 1'b1;
        end
    end

    // data bits then stop bit, lsb first.
    always_ff @(posedge clk) begin
        if (!busy && load) begin
            shifter <= {1'b1, data};
        end else if (bit_end && bits_left != '0) begin
            shifter <= {1'b1, shifter[8:1]};
        end
    end

endmodule

`default_nettype wire

// File: hdl/xc_control.sv
// host command decoder, integration gate and report serializer.
// report is two bytes per counter, low byte first.
`timescale 1ns/10ps
`default_nettype none

module xc_control #(
    parameter int NUM_LINES = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  uart_pkg::uart_rx_t                     rx_in,
    input  xc_pkg::xc_count_t                      count,
    input  logic                                   tx_busy,
    output logic                                   clear,
    output logic                                   accumulate,
    output logic [$clog2(xc_pkg::XC_PAIRS_MAX)-1:0] sel,
    output logic                                   tx_load,
    output uart_pkg::uart_byte_t                   tx_byte,
    output xc_pkg::xc_status_t                     status
);
    import uart_pkg::*;
    import xc_pkg::*;

    localparam int NUM_COUNTERS = NUM_LINES + NUM_LINES * (NUM_LINES - 1) / 2;
    localparam int SEL_W = $clog2(XC_PAIRS_MAX);
    localparam logic [SEL_W-1:0] LAST_SEL = SEL_W'(NUM_COUNTERS - 1);

    xc_state_e state;
    logic      high_half;
    logic      cmd_start;
    logic      cmd_stop;

    // command decode, other bytes fall through.
    assign cmd_start = rx_in.valid && (rx_in.data == CMD_START);
    assign cmd_stop  = rx_in.valid && (rx_in.data == CMD_STOP);

    // ========================================
    // control FSM.
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            clear     <= 1'b0;
            tx_load   <= 1'b0;
            sel       <= '0;
            high_half <= 1'b0;
        end else begin
            clear   <= 1'b0;
            tx_load <= 1'b0;
            case (state)
                idle, integrate: begin
                    if (cmd_start) begin
                        // restart from zero.
                        clear <= 1'b1;
                        state <= integrate;
                    end else if (cmd_stop) begin
                        sel       <= '0;
                        high_half <= 1'b0;
                        state     <= load_byte;
                    end
                end
                load_byte: begin
                    if (!tx_busy) begin
                        tx_load <= 1'b1;
                        state   <= wait_tx;
                    end
                end
                wait_tx: begin
                    // busy rises one cycle after the load.
                    if (!tx_load && !tx_busy) begin
                        if (!high_half) begin
                            high_half <= 1'b1;
                            state     <= load_byte;
                        end else if (sel == LAST_SEL) begin
                            state <= idle;
                        end else begin
                            sel       <= sel + 1'b1;
                            high_half <= 1'b0;
                            state     <= load_byte;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // byte picked from the selected counter.
    always_ff @(posedge clk) begin
        if (state == load_byte && !tx_busy) begin
            tx_byte <= high_half ? count[15:8] : count[7:0];
        end
    end

    assign accumulate         = (state == integrate);
    assign status.integrating = (state == integrate);
    assign status.report_busy = (state == load_byte) || (state == wait_tx);

endmodule

`default_nettype wire

// File: hdl/xc_correlator.sv
// lag zero auto and cross coincidence counters with a one counter readout mux.
`timescale 1ns/10ps
`default_nettype none

module xc_correlator #(
    parameter int NUM_LINES = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [NUM_LINES-1:0]                   line_in,
    input  logic                                   enable,
    input  logic                                   accumulate,
    input  logic                                   clear,
    input  logic [$clog2(xc_pkg::XC_PAIRS_MAX)-1:0] sel,
    output xc_pkg::xc_count_t                      count
);
    import xc_pkg::*;

    localparam int NUM_COUNTERS = NUM_LINES + NUM_LINES * (NUM_LINES - 1) / 2;
    localparam int SEL_W = $clog2(XC_PAIRS_MAX);

    logic [NUM_LINES-1:0]    line_meta;
    logic [NUM_LINES-1:0]    line_sync;
    logic                    enable_meta;
    logic                    enable_sync;
    logic                    sample;
    logic [NUM_COUNTERS-1:0] hit;
    xc_count_t               counter [NUM_COUNTERS];

    // two stage synchronizer, enable kept aligned with the lines.
    always_ff @(posedge clk) begin
        if (rst) begin
            line_meta   <= '0;
            line_sync   <= '0;
            enable_meta <= 1'b0;
            enable_sync <= 1'b0;
        end else begin
            line_meta   <= line_in;
            line_sync   <= line_meta;
            enable_meta <= enable;
            enable_sync <= enable_meta;
        end
    end

    // ========================================
    // coincidence map.
    // ========================================
    genvar i, j;
    generate
        // auto counters first.
        for (i = 0; i < NUM_LINES; i++) begin : g_auto
            assign hit[i] = line_sync[i];
        end
        // then pairs i < j in ascending order.
        for (i = 0; i < NUM_LINES - 1; i++) begin : g_row
            for (j = i + 1; j < NUM_LINES; j++) begin : g_col
                localparam int IDX = NUM_LINES + i * (2 * NUM_LINES - i - 1) / 2 + (j - i - 1);
                assign hit[IDX] = line_sync[i] & line_sync[j];
            end
        end
    endgenerate

    // gated sample.
    assign sample = enable_sync & accumulate;

    // saturating counters.
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            for (int k = 0; k < NUM_COUNTERS; k++) begin
                counter[k] <= '0;
            end
        end else if (sample) begin
            for (int k = 0; k < NUM_COUNTERS; k++) begin
                if (hit[k] && counter[k] != '1) begin
                    counter[k] <= counter[k] + 1'b1;
                end
            end
        end
    end

    // readout mux, unused select codes read zero.
    always_comb begin
        count = '0;
        for (int k = 0; k < NUM_COUNTERS; k++) begin
            if (sel == SEL_W'(k)) begin
                count = counter[k];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/xc_pkg.sv
// correlator types and constants shared by the correlator, control and top level.
// import inside a module body, or use scoped names in port lists.
`default_nettype none

package xc_pkg;

    // one correlation counter, saturating at all ones.
    typedef logic [15:0] xc_count_t;

    // upper bound on auto plus cross counters.
    // the counter select bus is sized from it.
    localparam int XC_PAIRS_MAX = 256;

    // host visible flags.
    typedef struct packed {
        logic integrating;
        logic report_busy;
    } xc_status_t;

    // control FSM states.
    typedef enum logic [1:0] {
        idle,
        integrate,
        load_byte,
        wait_tx
    } xc_state_e;

endpackage

`default_nettype wire

// File: hdl/xc_top.sv
// correlator top level, serial host link around the counter datapath.
`timescale 1ns/10ps
`default_nettype none

module xc_top #(
    parameter int NUM_LINES     = 4,
    parameter int CLK_FREQUENCY = 50_000_000,
    parameter int BAUD_RATE     = 3_125_000
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [NUM_LINES-1:0]  line_in,
    input  logic                  enable,
    input  logic                  rx,
    output logic                  tx,
    output xc_pkg::xc_status_t    status
);
    import uart_pkg::*;
    import xc_pkg::*;

    localparam int CLKS_PER_BIT = CLK_FREQUENCY / BAUD_RATE;

    uart_rx_t                        rx_data;
    xc_count_t                       count;
    logic                            clear;
    logic                            accumulate;
    logic [$clog2(XC_PAIRS_MAX)-1:0] sel;
    logic                            tx_load;
    logic                            tx_busy;
    uart_byte_t                      tx_byte;

    // ========================================
    // serial link.
    // ========================================
    uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) rx_i (
        .clk    (clk),
        .rst    (rst),
        .rx     (rx),
        .rx_out (rx_data)
    );

    uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) tx_i (
        .clk  (clk),
        .rst  (rst),
        .load (tx_load),
        .data (tx_byte),
        .tx   (tx),
        .busy (tx_busy)
    );

    // ========================================
    // counters and control.
    // ========================================
    xc_correlator #(.NUM_LINES(NUM_LINES)) corr_i (
        .clk        (clk),
        .rst        (rst),
        .line_in    (line_in),
        .enable     (enable),
        .accumulate (accumulate),
        .clear      (clear),
        .sel        (sel),
        .count      (count)
    );

    xc_control #(.NUM_LINES(NUM_LINES)) ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .rx_in      (rx_data),
        .count      (count),
        .tx_busy    (tx_busy),
        .clear      (clear),
        .accumulate (accumulate),
        .sel        (sel),
        .tx_load    (tx_load),
        .tx_byte    (tx_byte),
        .status     (status)
    );

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# build the correlator testbench with Verilator, run it, judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module xc_tb -f all.f
status=0
./obj_dir/Vxc_tb +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log
if grep -qx "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, exit status $status"
    exit 1
fi

// File: testbench/tb_clock.sv
// free running clock for the testbench.
`timescale 1ns/10ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);
    // starts low, first rising edge at half a period.
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: testbench/xc_assert.sv
// concurrent protocol properties on the correlator top level, attached by bind.
`timescale 1ns/10ps
`default_nettype none

module xc_assert (
    input logic               clk,
    input logic               rst,
    input logic               tx,
    input logic               tx_load,
    input logic               tx_busy,
    input logic               accumulate,
    input xc_pkg::xc_status_t status
);
    // failures per property.
    int idle_fails;
    int load_fails;
    int accum_fails;

    // line idles high outside integration and reports.
    tx_idle_high: assert property (@(posedge clk) disable iff (rst)
        (!status.integrating && !status.report_busy) |-> tx)
    else begin
        idle_fails++;
        $error("tx low with neither integration nor a report running");
    end

    // transmitter only loaded when free.
    load_when_free: assert property (@(posedge clk) disable iff (rst)
        !(tx_load && tx_busy))
    else begin
        load_fails++;
        $error("tx_load pulsed while tx_busy was high");
    end

    // no counting during a report or while a byte is on the line.
    no_accum_in_report: assert property (@(posedge clk) disable iff (rst)
        !(accumulate && (status.report_busy || tx_busy)))
    else begin
        accum_fails++;
        $error("accumulate high while a report or a byte was being sent");
    end

endmodule

bind xc_top xc_assert xc_assert_i (
    .clk        (clk),
    .rst        (rst),
    .tx         (tx),
    .tx_load    (tx_load),
    .tx_busy    (tx_busy),
    .accumulate (accumulate),
    .status     (status)
);

`default_nettype wire

// File: testbench/xc_checker.sv
// reference counter model and serial report decoder for the correlator testbench.
// compares every reported counter against the model and the table value.
`timescale 1ns/10ps
`default_nettype none

module xc_checker #(
    parameter int NUM_LINES = 4,
    parameter int BIT_CLKS  = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [NUM_LINES-1:0] line_in,
    input  logic                 enable,
    input  logic                 tx,
    input  xc_pkg::xc_status_t   status,
    input  int                   exp_count,
    input  int                   stops_sent,
    output int                   value_errors,
    output int                   frame_errors
);
    localparam int NUM_COUNTERS = NUM_LINES + NUM_LINES * (NUM_LINES - 1) / 2;
    localparam int REPORT_BYTES = 2 * NUM_COUNTERS;
    localparam int COUNT_MAX    = 65535;

    int                   model [NUM_COUNTERS];
    logic [NUM_LINES-1:0] line_d1;
    logic [NUM_LINES-1:0] line_d2;
    logic                 en_d1;
    logic                 en_d2;
    logic                 integ_q;
    logic                 busy_q;
    logic                 in_frame;
    int                   tick;
    int                   bit_n;
    logic [7:0]           data_sr;
    logic [7:0]           low_byte;
    int                   byte_idx;
    int                   reports_seen;

    // counter step, holds at the top.
    function automatic int saturate_inc(input int v);
        return (v < COUNT_MAX) ? v + 1 : v;
    endfunction

    // ========================================
    // counter model.
    // ========================================
    always @(posedge clk) begin : model_update
        int idx;
        if (rst) begin
            line_d1 <= '0;
            line_d2 <= '0;
            en_d1   <= 1'b0;
            en_d2   <= 1'b0;
            integ_q <= 1'b0;
            for (int k = 0; k < NUM_COUNTERS; k++) begin
                model[k] = 0;
            end
        end else begin
            // two cycle delay, same as the input synchronizer.
            line_d1 <= line_in;
            line_d2 <= line_d1;
            en_d1   <= enable;
            en_d2   <= en_d1;
            integ_q <= status.integrating;
            if (status.integrating && !integ_q) begin
                // start of integration clears everything.
                for (int k = 0; k < NUM_COUNTERS; k++) begin
                    model[k] = 0;
                end
            end else if (status.integrating && en_d2) begin
                // auto counters for each line.
                for (int i = 0; i < NUM_LINES; i++) begin
                    if (line_d2[i]) begin
                        model[i] = saturate_inc(model[i]);
                    end
                end
                // cross pairs, i below j, ascending.
                idx = NUM_LINES;
                for (int i = 0; i < NUM_LINES - 1; i++) begin
                    for (int j = i + 1; j < NUM_LINES; j++) begin
                        if (line_d2[i] && line_d2[j]) begin
                            model[idx] = saturate_inc(model[idx]);
                        end
                        idx++;
                    end
                end
            end
        end
    end

    // ========================================
    // report decoder.
    // ========================================
    always @(posedge clk) begin : frame_decode
        int value;
        if (rst) begin
            busy_q       <= 1'b0;
            in_frame     <= 1'b0;
            tick         <= 0;
            bit_n        <= 0;
            data_sr      <= '0;
            low_byte     <= '0;
            byte_idx     <= 0;
            reports_seen <= 0;
            value_errors <= 0;
            frame_errors <= 0;
        end else begin
            busy_q <= status.report_busy;
            // report boundaries.
            if (status.report_busy && !busy_q) begin
                byte_idx     <= 0;
                reports_seen <= reports_seen + 1;
                if (reports_seen >= stops_sent) begin
                    $display("a report started at %0t without a stop command", $time);
                    frame_errors <= frame_errors + 1;
                end
            end
            if (!status.report_busy && busy_q && byte_idx != REPORT_BYTES) begin
                $display("report ended after %0d of %0d bytes, bytes are missing",
                         byte_idx, REPORT_BYTES);
                frame_errors <= frame_errors + 1;
            end
            // frame sampling at mid bit.
            if (!in_frame) begin
                if (!tx) begin
                    in_frame <= 1'b1;
                    tick     <= BIT_CLKS + BIT_CLKS / 2 - 1;
                    bit_n    <= 0;
                end
            end else if (tick != 0) begin
                tick <= tick - 1;
            end else if (bit_n < 8) begin
                data_sr <= {tx, data_sr[7:1]};
                bit_n   <= bit_n + 1;
                tick    <= BIT_CLKS - 1;
            end else begin
                in_frame <= 1'b0;
                if (!tx) begin
                    $display("stop bit low on a byte sent at %0t", $time);
                    frame_errors <= frame_errors + 1;
                end else if (!status.report_busy || byte_idx >= REPORT_BYTES) begin
                    $display("extra byte 0x%02h sent outside a report at %0t", data_sr, $time);
                    frame_errors <= frame_errors + 1;
                end else if (byte_idx[0] == 1'b0) begin
                    // low byte first.
                    low_byte <= data_sr;
                    byte_idx <= byte_idx + 1;
                end else begin
                    value = {16'd0, data_sr, low_byte};
                    if (value != model[byte_idx / 2]) begin
                        $display("error at %0t: counter %0d read %0d, model %0d",
                                 $time, byte_idx / 2, value, model[byte_idx / 2]);
                        value_errors <= value_errors + 1;
                    end else if (exp_count >= 0 && value != exp_count) begin
                        $display("error at %0t: counter %0d read %0d, table expects %0d",
                                 $time, byte_idx / 2, value, exp_count);
                        value_errors <= value_errors + 1;
                    end
                    byte_idx <= byte_idx + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/xc_tb.sv
// correlator testbench, table driven host commands and line patterns.
// the checker compares the serial reports, the watchdog bounds the run.
`timescale 1ns/10ps
`default_nettype none

module xc_tb;
    import xc_pkg::*;
    import uart_pkg::*;

    localparam int NUM_LINES     = 4;
    localparam int CLK_FREQUENCY = 50_000_000;
    localparam int BAUD_RATE     = 3_125_000;
    localparam int BIT_CLKS      = CLK_FREQUENCY / BAUD_RATE;
    localparam int FRAME_CLKS    = 10 * BIT_CLKS;
    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 8;
    localparam int DRIVE_DELAY   = 2;
    localparam int NUM_COUNTERS  = NUM_LINES + NUM_LINES * (NUM_LINES - 1) / 2;
    localparam int REPORT_CLKS   = 2 * NUM_COUNTERS * (FRAME_CLKS + 4);

    typedef enum logic [1:0] {
        pat_random,
        pat_ones,
        pat_zeros,
        pat_pairs
    } pattern_e;

    // one test row.
    // cmd 00 sends nothing, exp_count -1 leaves the value to the model.
    typedef struct packed {
        logic [7:0] cmd;
        int         cycles;
        pattern_e   mode;
        logic       report;
        int         exp_count;
    } test_row_t;

    localparam int NUM_TESTS = 7;
    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{8'h00, 60,    pat_random, 1'b0, -1},
        '{8'h01, 100,   pat_ones,   1'b1, 100},
        '{8'h55, 40,    pat_ones,   1'b1, 100},
        '{8'h01, 300,   pat_random, 1'b1, -1},
        '{8'h01, 200,   pat_zeros,  1'b1, 0},
        '{8'h01, 150,   pat_pairs,  1'b1, -1},
        '{8'h01, 70000, pat_ones,   1'b1, 65535}
    };

    logic                 clk;
    logic                 rst;
    logic [NUM_LINES-1:0] line_in;
    logic                 enable;
    logic                 rx;
    logic                 tx;
    xc_status_t           status;
    logic [15:0]          lfsr;
    int                   stops_sent;
    int                   exp_count;
    int                   value_errors;
    int                   frame_errors;
    int                   local_errors;

    tb_clock #(.PERIOD_NS(CLK_PERIOD)) clock_i (
        .clk (clk)
    );

    xc_top #(
        .NUM_LINES     (NUM_LINES),
        .CLK_FREQUENCY (CLK_FREQUENCY),
        .BAUD_RATE     (BAUD_RATE)
    ) dut_i (
        .clk     (clk),
        .rst     (rst),
        .line_in (line_in),
        .enable  (enable),
        .rx      (rx),
        .tx      (tx),
        .status  (status)
    );

    xc_checker #(.NUM_LINES(NUM_LINES), .BIT_CLKS(BIT_CLKS)) checker_i (
        .clk          (clk),
        .rst          (rst),
        .line_in      (line_in),
        .enable       (enable),
        .tx           (tx),
        .status       (status),
        .exp_count    (exp_count),
        .stops_sent   (stops_sent),
        .value_errors (value_errors),
        .frame_errors (frame_errors)
    );

    // galois lfsr, taps 16 14 13 11.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // clock budget from the table plus a margin.
    function automatic int run_budget();
        int total;
        total = RESET_CYCLES + 20 * FRAME_CLKS;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += TESTS[t].cycles + 2 * FRAME_CLKS;
            if (TESTS[t].report) begin
                total += 2 * NUM_COUNTERS * FRAME_CLKS;
            end
        end
        return total;
    endfunction

    // n rising edges, then the drive offset.
    task automatic step(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // ========================================
    // host side serial driver.
    // ========================================
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int k = 0; k < 10; k++) begin
            rx = frame[k];
            step(BIT_CLKS);
        end
    endtask

    // one sample of the line pattern.
    task automatic drive_lines(input pattern_e mode, input int c);
        logic [NUM_LINES-1:0] v;
        v = '0;
        case (mode)
            pat_random: begin
                for (int k = 0; k < NUM_LINES; k++) begin
                    v[k] = lfsr[0];
                    lfsr = lfsr_step(lfsr);
                end
            end
            pat_ones:  v = '1;
            pat_zeros: v = '0;
            default: begin
                // pairs of lines swap every cycle.
                for (int k = 0; k < NUM_LINES; k++) begin
                    v[k] = (((k / 2) % 2) == (c % 2));
                end
            end
        endcase
        line_in = v;
    endtask

    task automatic wait_integrating();
        int n;
        n = 0;
        while (!status.integrating && n < FRAME_CLKS) begin
            step(1);
            n++;
        end
        if (!status.integrating) begin
            $display("integration did not start after the start command");
            local_errors++;
        end
    endtask

    task automatic wait_report();
        int n;
        n = 0;
        while (!status.report_busy && n < FRAME_CLKS) begin
            step(1);
            n++;
        end
        if (!status.report_busy) begin
            $display("no report followed the stop command");
            local_errors++;
        end else begin
            n = 0;
            while (status.report_busy && n < REPORT_CLKS) begin
                step(1);
                n++;
            end
            if (status.report_busy) begin
                $display("the report did not finish in time");
                local_errors++;
            end
        end
    endtask

    task automatic run_test(input test_row_t row);
        exp_count = row.exp_count;
        if (row.cmd != 8'h00) begin
            send_byte(row.cmd);
        end
        if (row.cmd == CMD_START) begin
            wait_integrating();
        end
        enable = 1'b1;
        for (int c = 0; c < row.cycles; c++) begin
            drive_lines(row.mode, c);
            step(1);
        end
        enable  = 1'b0;
        line_in = '0;
        step(4);
        if (row.report) begin
            stops_sent++;
            send_byte(CMD_STOP);
            wait_report();
        end
    endtask

    // ========================================
    // main sequence.
    // ========================================
    initial begin : main
        int assert_errors;
        int total;
        rst          = 1'b1;
        line_in      = '0;
        enable       = 1'b0;
        rx           = 1'b1;
        lfsr         = 16'd50;
        stops_sent   = 0;
        exp_count    = -1;
        local_errors = 0;
        step(RESET_CYCLES);
        rst = 1'b0;
        step(4);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(TESTS[t]);
        end
        // quiet tail, catches stray frames.
        step(2 * FRAME_CLKS);
        assert_errors = dut_i.xc_assert_i.idle_fails + dut_i.xc_assert_i.load_fails
                      + dut_i.xc_assert_i.accum_fails;
        total = value_errors + frame_errors + local_errors + assert_errors;
        $display("errors: value %0d, report %0d, sequence %0d, assertion %0d",
                 value_errors, frame_errors, local_errors, assert_errors);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // hang guard.
    initial begin : watchdog
        int limit;
        limit = run_budget();
        repeat (limit) @(posedge clk);
        $display("timeout, the run did not finish within %0d clock cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
